// File: logic/sqrt_cfg.svh
`ifndef SQRT_CFG_SVH
`define SQRT_CFG_SVH

// ----------------------------------------------------------------------
// datapath widths
// ----------------------------------------------------------------------
`define SQRT_OPERAND_WIDTH 64 // raw Q32.32 operand
`define SQRT_RESULT_WIDTH 32 // raw Q16.16 result
`define SQRT_ITERATIONS 32 // one result bit per cycle

// queue depths
`define SQRT_OPERAND_DEPTH 4
`define SQRT_RESULT_DEPTH 4

// ----------------------------------------------------------------------
// register map, byte offsets
// ----------------------------------------------------------------------
`define SQRT_REG_OPERAND_LO 32'h0000_0000
`define SQRT_REG_OPERAND_HI 32'h0000_0004 // write queues operand
`define SQRT_REG_STATUS 32'h0000_0008
`define SQRT_REG_RESULT 32'h0000_000C // read pops result

`endif

// File: logic/sqrtPkg.sv
package sqrtPkg;

	// ----------------------------------------------------------------------
	// payload types
	// ----------------------------------------------------------------------
	typedef logic [63:0] operand_t; // Q32.32, raw bits
	typedef logic [31:0] result_t; // Q16.16, raw bits

	// axi response codes
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// ----------------------------------------------------------------------
	// axi4-lite channels, 32-bit address and data
	// ----------------------------------------------------------------------
	// master to slave
	typedef struct packed {
		logic awValid;
		logic [31:0] awAddr;
		logic wValid;
		logic [31:0] wData; // no strobes, always full word
		logic bReady;
		logic arValid;
		logic [31:0] arAddr;
		logic rReady;
	} axiLiteReq_t;

	// slave to master
	typedef struct packed {
		logic awReady;
		logic wReady;
		logic bValid;
		logic [1:0] bResp;
		logic arReady;
		logic rValid;
		logic [31:0] rData;
		logic [1:0] rResp;
	} axiLiteRsp_t;

endpackage

// File: logic/syncFifo.sv
module syncFifo #(
	parameter type payload_t = logic [31:0],
	parameter int DEPTH = 4
) (
	input logic Clock,
	input logic rst,
	input logic push,
	input payload_t pushData,
	input logic pop,
	output payload_t popData,
	output logic full,
	output logic empty
);

	localparam int PtrWidth = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CountWidth = $clog2(DEPTH + 1);

	payload_t mem [DEPTH]; // storage, no reset
	logic [PtrWidth-1:0] wrPtr, rdPtr;
	logic [CountWidth-1:0] count;
	logic doPush, doPop;

	assign doPush = push && !full; // guard against overrun
	assign doPop = pop && !empty;

	assign full = (count == CountWidth'(DEPTH));
	assign empty = (count == '0);
	assign popData = mem[rdPtr]; // head visible without a pop

	// ----------------------------------------------------------------------
	// pointers and occupancy
	// ----------------------------------------------------------------------
	always_ff @(posedge Clock)
	begin
		if (rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= (wrPtr == PtrWidth'(DEPTH - 1)) ? '0 : wrPtr + 1'b1; // wrap
			if (doPop)
				rdPtr <= (rdPtr == PtrWidth'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			if (doPush && !doPop)
				count <= count + 1'b1;
			else if (doPop && !doPush)
				count <= count - 1'b1; // push with pop keeps count
		end
	end

	always_ff @(posedge Clock)
	begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

endmodule

// File: logic/fixedSqrtCore.sv
`include "sqrt_cfg.svh"

module fixedSqrtCore (
	input logic Clock,
	input logic rst,
	input logic inValid,
	output logic inReady,
	input sqrtPkg::operand_t operand,
	output logic outValid,
	input logic outReady,
	output sqrtPkg::result_t result,
	output logic busy
);

	// remainder never exceeds 2*root, plus two new operand bits
	localparam int RemWidth = `SQRT_RESULT_WIDTH + 3;
	localparam int CountWidth = $clog2(`SQRT_ITERATIONS);

	typedef enum logic [1:0] {
		Idle,
		Iterate,
		Hold
	} state_t;

	state_t state;

	logic [`SQRT_OPERAND_WIDTH-1:0] opShift; // operand, top pair consumed first
	logic [RemWidth-1:0] remainder;
	logic [RemWidth-1:0] remShifted; // remainder with next bit group
	logic [RemWidth-1:0] trial; // 4*root + 1
	logic [`SQRT_RESULT_WIDTH-1:0] root;
	logic [CountWidth-1:0] groupCount; // 31 down to 0
	logic fits;
	logic accept;

	// ----------------------------------------------------------------------
	// one iteration step
	// ----------------------------------------------------------------------
	always_comb
	begin
		remShifted = {remainder[RemWidth-3:0], opShift[`SQRT_OPERAND_WIDTH-1 -: 2]};
		trial = {1'b0, root, 2'b01};
		fits = (remShifted >= trial); // next result bit
	end

	assign accept = (state == Idle) && inValid;

	// control FSM
	always_ff @(posedge Clock)
	begin
		if (rst)
			state <= Idle;
		else
		begin
			case (state)
				Idle: if (inValid) state <= Iterate;
				Iterate: if (groupCount == '0) state <= Hold; // last bit done
				Hold: if (outReady) state <= Idle; // result taken
				default: state <= Idle;
			endcase
		end
	end

	// datapath, payload only
	always_ff @(posedge Clock)
	begin
		if (accept)
		begin
			opShift <= operand;
			remainder <= '0;
			root <= '0;
			groupCount <= CountWidth'(`SQRT_ITERATIONS - 1);
		end
		else if (state == Iterate)
		begin
			opShift <= opShift << 2;
			remainder <= fits ? remShifted - trial : remShifted; // subtract when it fits
			root <= {root[`SQRT_RESULT_WIDTH-2:0], fits};
			groupCount <= groupCount - 1'b1;
		end
	end

	assign inReady = (state == Idle);
	assign outValid = (state == Hold); // held until outReady
	assign busy = (state != Idle);
	assign result = root;

endmodule

// File: logic/axiLiteSqrtRegs.sv
`include "sqrt_cfg.svh"

module axiLiteSqrtRegs (
	input logic Clock,
	input logic rst,
	input sqrtPkg::axiLiteReq_t busReq,
	output sqrtPkg::axiLiteRsp_t busRsp,
	output logic opPush,
	output sqrtPkg::operand_t opData,
	input logic opFull,
	output logic resPop,
	input sqrtPkg::result_t resData,
	input logic resEmpty,
	input logic coreBusy
);

	// ----------------------------------------------------------------------
	// write channel
	// ----------------------------------------------------------------------
	logic bValid;
	logic [1:0] bResp;
	logic [31:0] loWord; // low operand half, waits for high write
	logic wrHandshake;
	logic wrIsLo, wrIsHi, wrOk;

	assign wrHandshake = busReq.awValid && busReq.wValid && !bValid; // addr and data together
	assign wrIsLo = (busReq.awAddr == `SQRT_REG_OPERAND_LO);
	assign wrIsHi = (busReq.awAddr == `SQRT_REG_OPERAND_HI);
	assign wrOk = wrIsLo || (wrIsHi && !opFull);

	// push only when there is room
	assign opPush = wrHandshake && wrIsHi && !opFull;
	assign opData = {busReq.wData, loWord};

	always_ff @(posedge Clock)
	begin
		if (rst)
			bValid <= 1'b0;
		else if (wrHandshake)
			bValid <= 1'b1;
		else if (busReq.bReady)
			bValid <= 1'b0; // response accepted
	end

	always_ff @(posedge Clock)
	begin
		if (wrHandshake)
		begin
			bResp <= wrOk ? sqrtPkg::RESP_OKAY : sqrtPkg::RESP_SLVERR;
			if (wrIsLo)
				loWord <= busReq.wData;
		end
	end

	// ----------------------------------------------------------------------
	// read channel
	// ----------------------------------------------------------------------
	logic rValid;
	logic [31:0] rData;
	logic [1:0] rResp;
	logic rdHandshake;
	logic rdIsStatus, rdIsResult;
	logic [31:0] statusWord;
	logic [31:0] rdNext; // data for the pending beat
	logic rdOk;

	assign rdHandshake = busReq.arValid && !rValid;
	assign rdIsStatus = (busReq.arAddr == `SQRT_REG_STATUS);
	assign rdIsResult = (busReq.arAddr == `SQRT_REG_RESULT);

	// full, result available, busy
	assign statusWord = {29'd0, coreBusy, !resEmpty, opFull};

	// pop on the address handshake, head captured same edge
	assign resPop = rdHandshake && rdIsResult && !resEmpty;

	always_comb
	begin
		rdNext = '0; // zero on any error
		rdOk = 1'b0;
		if (rdIsStatus)
		begin
			rdNext = statusWord;
			rdOk = 1'b1;
		end
		else if (rdIsResult && !resEmpty)
		begin
			rdNext = resData;
			rdOk = 1'b1;
		end
	end

	always_ff @(posedge Clock)
	begin
		if (rst)
			rValid <= 1'b0;
		else if (rdHandshake)
			rValid <= 1'b1;
		else if (busReq.rReady)
			rValid <= 1'b0;
	end

	always_ff @(posedge Clock)
	begin
		if (rdHandshake)
		begin
			rData <= rdNext;
			rResp <= rdOk ? sqrtPkg::RESP_OKAY : sqrtPkg::RESP_SLVERR;
		end
	end

	// ----------------------------------------------------------------------
	// response struct
	// ----------------------------------------------------------------------
	always_comb
	begin
		busRsp.awReady = wrHandshake; // one cycle, both channels
		busRsp.wReady = wrHandshake;
		busRsp.bValid = bValid;
		busRsp.bResp = bResp;
		busRsp.arReady = rdHandshake;
		busRsp.rValid = rValid;
		busRsp.rData = rData;
		busRsp.rResp = rResp;
	end

endmodule

// File: logic/sqrtCoprocessor.sv
`include "sqrt_cfg.svh"

module sqrtCoprocessor (
	input logic Clock,
	input logic rst,
	input sqrtPkg::axiLiteReq_t busReq,
	output sqrtPkg::axiLiteRsp_t busRsp
);

	// operand side
	logic opPush, opFull, opEmpty;
	sqrtPkg::operand_t opData, opHead;
	logic coreInReady; // doubles as operand pop

	// result side
	logic coreOutValid, resFull, resEmpty, resPop;
	sqrtPkg::result_t coreResult, resHead;
	logic coreBusy;

	// ----------------------------------------------------------------------
	// bus decoder, both paths
	// ----------------------------------------------------------------------
	axiLiteSqrtRegs regs_i (
		.Clock (Clock),
		.rst (rst),
		.busReq (busReq),
		.busRsp (busRsp),
		.opPush (opPush),
		.opData (opData),
		.opFull (opFull),
		.resPop (resPop),
		.resData (resHead),
		.resEmpty (resEmpty),
		.coreBusy (coreBusy)
	);

	syncFifo #(.payload_t(sqrtPkg::operand_t), .DEPTH(`SQRT_OPERAND_DEPTH)) operandQueue (
		.Clock (Clock),
		.rst (rst),
		.push (opPush),
		.pushData (opData),
		.pop (coreInReady),
		.popData (opHead),
		.full (opFull),
		.empty (opEmpty)
	);

	// not-empty is valid, idle core pops
	fixedSqrtCore core_i (
		.Clock (Clock),
		.rst (rst),
		.inValid (!opEmpty),
		.inReady (coreInReady),
		.operand (opHead),
		.outValid (coreOutValid),
		.outReady (!resFull), // full queue stalls core
		.result (coreResult),
		.busy (coreBusy)
	);

	syncFifo #(.payload_t(sqrtPkg::result_t), .DEPTH(`SQRT_RESULT_DEPTH)) resultQueue (
		.Clock (Clock),
		.rst (rst),
		.push (coreOutValid),
		.pushData (coreResult),
		.pop (resPop),
		.popData (resHead),
		.full (resFull),
		.empty (resEmpty)
	);

endmodule

// File: verification/sqrtCoprocessorTb.sv
`include "sqrt_cfg.svh"

module sqrtCoprocessorTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NumFixed = 6;
	localparam int NumRandom = 8;
	localparam int NumRows = NumFixed + NumRandom;
	localparam int NumTests = NumRows + 4 + 10 + 4; // rows, ordering, back-pressure, errors
	localparam int TimeoutCycles = NumTests * 100 + 1000;
	localparam int StallPolls = 30; // well past one core operation
	localparam int Accepted = `SQRT_RESULT_DEPTH + 1 + `SQRT_OPERAND_DEPTH;
	localparam logic [31:0] Unmapped = 32'h0000_0010;

	logic Clock;
	logic rst;
	sqrtPkg::axiLiteReq_t busReq;
	sqrtPkg::axiLiteRsp_t busRsp;

	int errorCount = 0;
	int cycleCount = 0;
	integer seed = 32'h90864bc5;

	// stimulus table
	string rowName [NumRows];
	logic [63:0] rowOperand [NumRows];
	logic [31:0] rowExpect [NumRows];

	sqrtCoprocessor dut_i (
		.Clock (Clock),
		.rst (rst),
		.busReq (busReq),
		.busRsp (busRsp)
	);

	initial Clock = 1'b0;
	always #10 Clock = ~Clock; // 20 ns period

	// ----------------------------------------------------------------------
	// watchdog
	// ----------------------------------------------------------------------
	always @(posedge Clock)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles)
		begin
			$display("timeout: the run did not finish within %0d cycles", TimeoutCycles);
			$display("errors: %0d", errorCount + 1);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// floor square root, one bit at a time from the top
	function automatic logic [31:0] refSqrt(input logic [63:0] value);
		logic [31:0] root;
		logic [31:0] cand;
		logic [63:0] square;
		root = '0;
		for (int b = 31; b >= 0; b--)
		begin
			cand = root | (32'd1 << b);
			square = 64'(cand) * 64'(cand); // fits, cand below 2^32
			if (square <= value)
				root = cand;
		end
		return root;
	endfunction

	task automatic checkValue(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected)
		begin
			$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
			errorCount++;
		end
	endtask

	// ----------------------------------------------------------------------
	// axi4-lite master
	// ----------------------------------------------------------------------
	task automatic busWrite(input logic [31:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		@(posedge Clock);
		busReq.awValid <= 1'b1;
		busReq.awAddr <= addr;
		busReq.wValid <= 1'b1;
		busReq.wData <= data;
		@(negedge Clock);
		while (!busRsp.awReady)
			@(negedge Clock);
		if (!busRsp.wReady)
		begin
			$display("write data channel not accepted together with the write address");
			errorCount++;
		end
		@(posedge Clock); // handshake edge
		busReq.awValid <= 1'b0;
		busReq.wValid <= 1'b0;
		busReq.bReady <= 1'b1;
		@(negedge Clock);
		while (!busRsp.bValid)
			@(negedge Clock);
		resp = busRsp.bResp;
		@(posedge Clock);
		busReq.bReady <= 1'b0;
	endtask

	task automatic busRead(input logic [31:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		@(posedge Clock);
		busReq.arValid <= 1'b1;
		busReq.arAddr <= addr;
		@(negedge Clock);
		while (!busRsp.arReady)
			@(negedge Clock);
		@(posedge Clock);
		busReq.arValid <= 1'b0;
		busReq.rReady <= 1'b1;
		@(negedge Clock);
		while (!busRsp.rValid)
			@(negedge Clock);
		data = busRsp.rData;
		resp = busRsp.rResp;
		@(posedge Clock);
		busReq.rReady <= 1'b0;
	endtask

	// lo word then hi word, hi response returned
	task automatic pushOperand(input string name, input logic [63:0] op,
		output logic [1:0] hiResp);
		logic [1:0] loResp;
		busWrite(`SQRT_REG_OPERAND_LO, op[31:0], loResp);
		checkValue({name, " lo resp"}, sqrtPkg::RESP_OKAY, loResp);
		busWrite(`SQRT_REG_OPERAND_HI, op[63:32], hiResp);
	endtask

	// poll status bit 1, then pop one result
	task automatic readResult(input string name, input logic [31:0] expected);
		logic [31:0] data;
		logic [1:0] resp;
		data = '0;
		while (!data[1])
			busRead(`SQRT_REG_STATUS, data, resp);
		busRead(`SQRT_REG_RESULT, data, resp);
		checkValue({name, " resp"}, sqrtPkg::RESP_OKAY, resp);
		checkValue(name, expected, data);
	endtask

	// ----------------------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------------------
	initial
	begin
		logic [31:0] data;
		logic [1:0] resp;
		logic [63:0] op;
		logic [63:0] orderOps [4];
		logic [63:0] pending [$];
		int polls;
		bit stalled;

		busReq = '0;
		rst = 1'b1;

		rowName[0] = "zero";
		rowOperand[0] = 64'd0;
		rowExpect[0] = 32'd0;
		rowName[1] = "one";
		rowOperand[1] = 64'd1;
		rowExpect[1] = 32'd1;
		rowName[2] = "square";
		rowOperand[2] = 64'd1524157875019052100;
		rowExpect[2] = 32'd1234567890; // exact root
		rowName[3] = "max";
		rowOperand[3] = 64'hFFFF_FFFF_FFFF_FFFF;
		rowExpect[3] = 32'hFFFF_FFFF;
		rowName[4] = "q one";
		rowOperand[4] = 64'h0000_0001_0000_0000;
		rowExpect[4] = 32'h0001_0000; // 1.0 in q16.16
		rowName[5] = "q two";
		rowOperand[5] = 64'h0000_0002_0000_0000;
		rowExpect[5] = 32'h0001_6A09; // sqrt 2 rounded down
		for (int i = NumFixed; i < NumRows; i++)
		begin
			rowName[i] = $sformatf("random %0d", i - NumFixed);
			rowOperand[i] = {$random(seed), $random(seed)};
			rowExpect[i] = refSqrt(rowOperand[i]);
		end

		repeat (10) @(posedge Clock);
		rst <= 1'b0;

		// error responses from an idle coprocessor
		busRead(`SQRT_REG_STATUS, data, resp);
		checkValue("status after reset", 32'd0, data);
		checkValue("status after reset resp", sqrtPkg::RESP_OKAY, resp);
		busRead(`SQRT_REG_RESULT, data, resp);
		checkValue("empty result resp", sqrtPkg::RESP_SLVERR, resp);
		checkValue("empty result data", 32'd0, data);
		busRead(Unmapped, data, resp);
		checkValue("unmapped read resp", sqrtPkg::RESP_SLVERR, resp);
		checkValue("unmapped read data", 32'd0, data);
		busWrite(Unmapped, 32'hDEAD_BEEF, resp);
		checkValue("unmapped write resp", sqrtPkg::RESP_SLVERR, resp);

		// table rows, one at a time
		for (int i = 0; i < NumRows; i++)
		begin
			pushOperand(rowName[i], rowOperand[i], resp);
			checkValue({rowName[i], " hi resp"}, sqrtPkg::RESP_OKAY, resp);
			// core mid-operation, nothing ready yet
			busRead(`SQRT_REG_STATUS, data, resp);
			checkValue({rowName[i], " status busy"}, 32'h0000_0004, data);
			readResult(rowName[i], rowExpect[i]);
		end

		// four in flight, read back in write order
		for (int k = 0; k < 4; k++)
		begin
			orderOps[k] = {$random(seed), $random(seed)};
			pushOperand("order", orderOps[k], resp);
			checkValue($sformatf("order %0d hi resp", k), sqrtPkg::RESP_OKAY, resp);
		end
		for (int k = 0; k < 4; k++)
			readResult($sformatf("order %0d", k), refSqrt(orderOps[k]));

		// ------------------------------------------------------------------
		// back-pressure, fill everything without reading
		// ------------------------------------------------------------------
		stalled = 1'b0;
		while (!stalled)
		begin
			polls = 0;
			busRead(`SQRT_REG_STATUS, data, resp);
			while (data[0] && polls < StallPolls) // operand queue full
			begin
				busRead(`SQRT_REG_STATUS, data, resp);
				polls++;
			end
			if (data[0])
				stalled = 1'b1; // stayed full, chain is stalled
			else
			begin
				op = {$random(seed), $random(seed)};
				pushOperand("fill", op, resp);
				if (resp != sqrtPkg::RESP_OKAY)
				begin
					$display("operand write refused although the operand queue was not full");
					errorCount++;
				end
				else
					pending.push_back(op);
			end
		end
		checkValue("accepted count", Accepted, pending.size());
		busWrite(`SQRT_REG_OPERAND_HI, 32'h1234_5678, resp);
		checkValue("full queue write resp", sqrtPkg::RESP_SLVERR, resp);

		// drain, oldest first
		for (int k = 0; k < pending.size(); k++)
			readResult($sformatf("drain %0d", k), refSqrt(pending[k]));

		$display("test run done, errors: %0d", errorCount);
		if (errorCount == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: sqrtCoprocessor.f
+incdir+logic
logic/sqrtPkg.sv
logic/syncFifo.sv
logic/fixedSqrtCore.sv
logic/axiLiteSqrtRegs.sv
logic/sqrtCoprocessor.sv
verification/sqrtCoprocessorTb.sv

// File: Bender.yml
package:
  name: sqrt_coprocessor

sources:
  - include_dirs:
      - logic
    files:
      - logic/sqrtPkg.sv
      - logic/syncFifo.sv
      - logic/fixedSqrtCore.sv
      - logic/axiLiteSqrtRegs.sv
      - logic/sqrtCoprocessor.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/sqrtCoprocessorTb.sv
